//--- src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Lanes in one register row
`define LSU_LANES 8

// Memory word width of each lane access
`define LSU_WORD_W 32

`define LSU_VADDR_W 10  // Vector register file address
`define LSU_SADDR_W 9   // Scalar register file address

`define LSU_WFID_W 6

// Rows minus one allows up to four rows per operation
`define LSU_DEPTH_W 2

`endif

//--- src/lsu_pkg.sv
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_WORD_W-1:0] word_t;
    typedef logic [`LSU_LANES*`LSU_WORD_W-1:0] lane_vec_t;  // One word per lane
    typedef logic [`LSU_LANES-1:0] lane_mask_t;
    typedef logic [$clog2(`LSU_LANES)-1:0] lane_idx_t;     // Lane index or op count

    typedef logic [`LSU_VADDR_W-1:0] vaddr_t;
    typedef logic [`LSU_SADDR_W-1:0] saddr_t;
    typedef logic [`LSU_WFID_W-1:0] wfid_t;
    typedef logic [`LSU_DEPTH_W-1:0] depth_t;

    // Operation sequence
    typedef enum logic [2:0] {
        idle,
        addr,           // Lane addresses and memory space valid
        mem_access,
        reg_write,      // Gathered row goes to the register file
        reg_read_req,
        reg_read_data,  // Source row returns from the vector register file
        done
    } lsu_state_t;

endpackage

`default_nettype wire

//--- src/lsu_ctrl.sv
`default_nettype none

module lsu_ctrl import lsu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   mem_op_rd,
    input  logic   mem_op_wr,
    input  wfid_t  lsu_wfid,
    input  logic [31:0] instr_pc,
    input  logic   mem_gpr,
    input  logic   gm_or_lds,
    input  depth_t gpr_op_depth,
    input  logic   row_end,
    output logic   lsu_rdy,
    output logic   lsu_done,
    output wfid_t  lsu_done_wfid,
    output logic   sgpr_instr_done,
    output logic   vgpr_instr_done,
    output logic [31:0] retire_pc,
    output logic   retire_gm_or_lds,
    output logic   mem_gm_or_lds,
    output logic   op_start,
    output logic   row_start,
    output logic   is_write,
    output logic   is_vector,
    output logic   gpr_wr,
    output logic   vgpr_rd_req,
    output logic   vgpr_capture
);

    lsu_state_t state;
    lsu_state_t state_next;
    depth_t depth_q;
    depth_t row_cnt;
    wfid_t wfid_q;
    logic [31:0] pc_q;
    logic last_row;
    logic row_done;

    assign last_row = (row_cnt == depth_q);

    // A read row closes on its register write, a write row on its last store
    assign row_done = (state == reg_write) || (state == mem_access && is_write && row_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            is_write <= 1'b0;
            is_vector <= 1'b0;
            depth_q <= '0;
            row_cnt <= '0;
        end else begin
            state <= state_next;
            if (op_start) begin
                is_write <= mem_op_wr;
                is_vector <= mem_op_wr | mem_gpr;  // Stores always come from a vector row
                depth_q <= gpr_op_depth;
                row_cnt <= '0;
            end else if (row_done) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_start) begin
            wfid_q <= lsu_wfid;
            pc_q <= instr_pc;
        end
        if (state == addr)
            mem_gm_or_lds <= gm_or_lds;  // Valid one cycle after acceptance
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (mem_op_rd || mem_op_wr)
                    state_next = addr;
            end
            addr: state_next = is_write ? reg_read_req : mem_access;
            mem_access: begin
                if (row_end && !is_write)
                    state_next = reg_write;
                else if (row_end)
                    state_next = last_row ? done : reg_read_req;
            end
            reg_write: state_next = last_row ? done : mem_access;
            reg_read_req: state_next = reg_read_data;
            reg_read_data: state_next = mem_access;
            done: state_next = idle;
            default: state_next = idle;
        endcase
    end

    assign op_start = (state == idle) && (mem_op_rd || mem_op_wr);

    // Memory phase of the next row begins in the following cycle
    assign row_start = (state == addr && !is_write) ||
                       (state == reg_write && !last_row) ||
                       (state == reg_read_data);

    assign gpr_wr = (state == reg_write);
    assign vgpr_rd_req = (state == reg_read_req);
    assign vgpr_capture = (state == reg_read_data);

    assign lsu_rdy = (state == idle);
    assign lsu_done = (state == done);
    assign lsu_done_wfid = wfid_q;
    assign sgpr_instr_done = lsu_done && !is_write && !is_vector;
    assign vgpr_instr_done = lsu_done && !is_write && is_vector;
    assign retire_pc = lsu_done ? pc_q : 32'd0;
    assign retire_gm_or_lds = lsu_done ? mem_gm_or_lds : 1'b0;

endmodule

`default_nettype wire

//--- src/lsu_mem_seq.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_mem_seq import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       op_start,
    input  logic       row_start,
    input  logic       is_write,
    input  logic       is_vector,
    input  lane_idx_t  mem_op_cnt,
    input  lane_vec_t  mem_in_addr,
    input  lane_mask_t exec_base,
    input  logic       mem_ack,
    output logic       mem_rd_en,
    output logic       mem_wr_en,
    output word_t      mem_out_addr,
    output logic       word_ack,
    output lane_idx_t  lane_index,
    output logic       row_end
);

    localparam int W = `LSU_WORD_W;

    lane_vec_t base_addr;    // Lane addresses of row 0
    lane_vec_t lane_addr;    // Current lane sits in word 0
    lane_vec_t reload_addr;
    word_t row_off;          // 4 times the row index
    lane_mask_t mask_q;
    lane_idx_t op_cnt_q;
    lane_idx_t cnt;
    logic op_start_q;
    logic busy;
    logic skip;
    logic strobe;

    // Row 0 can start in the very cycle the addresses are sampled
    always_comb begin
        for (int i = 0; i < `LSU_LANES; i++)
            reload_addr[i*W +: W] = (op_start_q ? mem_in_addr[i*W +: W] : base_addr[i*W +: W])
                                    + row_off;
    end

    assign skip = is_vector && !mask_q[0];  // Inactive lane ends a vector row
    assign strobe = busy && !skip;
    assign mem_rd_en = strobe && !is_write;
    assign mem_wr_en = strobe && is_write;
    assign word_ack = strobe && mem_ack;
    assign row_end = busy && (skip || (mem_ack && cnt == op_cnt_q));
    assign lane_index = cnt;
    assign mem_out_addr = lane_addr[W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= '0;
            row_off <= '0;
            op_start_q <= 1'b0;
        end else begin
            op_start_q <= op_start;
            if (op_start)
                row_off <= '0;
            if (row_start) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (row_end) begin
                busy <= 1'b0;
                row_off <= row_off + word_t'(4);
            end else if (word_ack) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_start)
            op_cnt_q <= mem_op_cnt;
        if (op_start_q)
            base_addr <= mem_in_addr;
        if (row_start) begin
            lane_addr <= reload_addr;
            mask_q <= exec_base;
        end else if (word_ack) begin
            mask_q <= mask_q >> 1;
            if (!is_vector)
                lane_addr[W-1:0] <= lane_addr[W-1:0] + word_t'(4);  // Scalar words are contiguous
            else
                lane_addr <= lane_addr >> W;
        end
    end

endmodule

`default_nettype wire

//--- src/lsu_lane_buffer.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_lane_buffer import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      is_write,
    input  logic      word_ack,
    input  lane_idx_t lane_index,
    input  word_t     mem_rd_data,
    input  logic      vgpr_capture,
    input  lane_vec_t vgpr_source1_data,
    output lane_vec_t lane_data,
    output word_t     mem_wr_data
);

    lane_vec_t data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_q <= '0;
        end else if (vgpr_capture) begin
            data_q <= vgpr_source1_data;  // Whole source row for a store
        end else if (word_ack) begin
            if (is_write)
                data_q <= data_q >> `LSU_WORD_W;  // Next lane moves into word 0
            else
                data_q[lane_index*`LSU_WORD_W +: `LSU_WORD_W] <= mem_rd_data;
        end
    end

    assign lane_data = data_q;

    // Store data always comes from word 0
    assign mem_wr_data = data_q[`LSU_WORD_W-1:0];

endmodule

`default_nettype wire

//--- src/lsu_writeback.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_writeback import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       op_start,
    input  logic       is_vector,
    input  logic       gpr_wr,
    input  logic       vgpr_rd_req,
    input  lane_mask_t exec_mask,
    input  logic [3:0] sgpr_wr_mask,
    input  vaddr_t     decoded_dest_addr,
    input  vaddr_t     decoded_vgpr_source1_addr,
    input  lane_vec_t  lane_data,
    output logic [4*`LSU_WORD_W-1:0] sgpr_dest_data,
    output saddr_t     sgpr_dest_addr,
    output logic [3:0] sgpr_dest_wr_en,
    output lane_vec_t  vgpr_dest_data,
    output vaddr_t     vgpr_dest_addr,
    output logic       vgpr_dest_wr_en,
    output lane_mask_t vgpr_wr_mask,
    output logic       vgpr_source1_rd_en,
    output vaddr_t     vgpr_source1_addr,
    output lane_mask_t exec_base
);

    vaddr_t dest_addr_q;
    vaddr_t src_addr_q;
    logic [3:0] wr_mask_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            dest_addr_q <= '0;
            src_addr_q <= '0;
            exec_base <= '0;
            wr_mask_q <= '0;
        end else if (op_start) begin
            dest_addr_q <= decoded_dest_addr;
            src_addr_q <= decoded_vgpr_source1_addr;
            exec_base <= exec_mask;
            wr_mask_q <= sgpr_wr_mask;
        end else begin
            if (gpr_wr)
                dest_addr_q <= dest_addr_q + 1'b1;  // Next row goes one register up
            if (vgpr_rd_req)
                src_addr_q <= src_addr_q + 1'b1;
        end
    end

    // Scalar rows take the low four words only
    assign sgpr_dest_data = lane_data[4*`LSU_WORD_W-1:0];
    assign sgpr_dest_addr = dest_addr_q[`LSU_SADDR_W-1:0];
    assign sgpr_dest_wr_en = {4{gpr_wr && !is_vector}} & wr_mask_q;

    assign vgpr_dest_data = lane_data;
    assign vgpr_dest_addr = dest_addr_q;
    assign vgpr_dest_wr_en = gpr_wr && is_vector;
    assign vgpr_wr_mask = exec_base;

    assign vgpr_source1_rd_en = vgpr_rd_req;
    assign vgpr_source1_addr = src_addr_q;

endmodule

`default_nettype wire

//--- src/lsu_top.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_top import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  wfid_t      lsu_wfid,
    input  logic [31:0] instr_pc,
    input  lane_idx_t  mem_op_cnt,
    input  logic       mem_op_rd,
    input  logic       mem_op_wr,
    input  logic       mem_gpr,
    input  logic       gm_or_lds,
    input  logic [3:0] sgpr_wr_mask,
    input  depth_t     gpr_op_depth,
    input  lane_mask_t exec_mask,
    input  lane_vec_t  mem_in_addr,
    input  logic       mem_ack,
    input  word_t      mem_rd_data,
    input  lane_vec_t  vgpr_source1_data,
    input  vaddr_t     decoded_vgpr_source1_addr,
    input  vaddr_t     decoded_dest_addr,
    output logic [4*`LSU_WORD_W-1:0] sgpr_dest_data,
    output logic [3:0] sgpr_dest_wr_en,
    output saddr_t     sgpr_dest_addr,
    output lane_vec_t  vgpr_dest_data,
    output logic       vgpr_dest_wr_en,
    output lane_mask_t vgpr_wr_mask,
    output vaddr_t     vgpr_dest_addr,
    output logic       lsu_rdy,
    output logic       lsu_done,
    output wfid_t      lsu_done_wfid,
    output logic       sgpr_instr_done,
    output logic       vgpr_instr_done,
    output logic [31:0] retire_pc,
    output logic       retire_gm_or_lds,
    output logic       mem_rd_en,
    output logic       mem_wr_en,
    output word_t      mem_out_addr,
    output word_t      mem_wr_data,
    output logic [`LSU_WFID_W:0] mem_tag_req,
    output logic       mem_gm_or_lds,
    output logic       vgpr_source1_rd_en,
    output vaddr_t     vgpr_source1_addr
);

    logic op_start;
    logic row_start;
    logic is_write;
    logic is_vector;
    logic gpr_wr;
    logic vgpr_rd_req;
    logic vgpr_capture;
    logic word_ack;
    logic row_end;
    lane_idx_t lane_index;
    lane_mask_t exec_base;
    lane_vec_t lane_data;

    // Read tag carries the owning wavefront
    assign mem_tag_req = {lsu_done_wfid, mem_rd_en};

    lsu_ctrl ctrl_inst (
        .clk, .rst, .mem_op_rd, .mem_op_wr, .lsu_wfid, .instr_pc, .mem_gpr, .gm_or_lds,
        .gpr_op_depth, .row_end, .lsu_rdy, .lsu_done, .lsu_done_wfid, .sgpr_instr_done,
        .vgpr_instr_done, .retire_pc, .retire_gm_or_lds, .mem_gm_or_lds, .op_start,
        .row_start, .is_write, .is_vector, .gpr_wr, .vgpr_rd_req, .vgpr_capture
    );

    lsu_mem_seq mem_seq_inst (
        .clk, .rst, .op_start, .row_start, .is_write, .is_vector, .mem_op_cnt, .mem_in_addr,
        .exec_base, .mem_ack, .mem_rd_en, .mem_wr_en, .mem_out_addr, .word_ack, .lane_index,
        .row_end
    );

    lsu_lane_buffer lane_buffer_inst (
        .clk, .rst, .is_write, .word_ack, .lane_index, .mem_rd_data, .vgpr_capture,
        .vgpr_source1_data, .lane_data, .mem_wr_data
    );

    lsu_writeback writeback_inst (
        .clk, .rst, .op_start, .is_vector, .gpr_wr, .vgpr_rd_req, .exec_mask, .sgpr_wr_mask,
        .decoded_dest_addr, .decoded_vgpr_source1_addr, .lane_data, .sgpr_dest_data,
        .sgpr_dest_addr, .sgpr_dest_wr_en, .vgpr_dest_data, .vgpr_dest_addr, .vgpr_dest_wr_en,
        .vgpr_wr_mask, .vgpr_source1_rd_en, .vgpr_source1_addr, .exec_base
    );

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/tb_lsu.sv
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_OPS = 5;
    localparam int W = `LSU_WORD_W;

    logic clk;
    logic rst;
    wfid_t lsu_wfid;
    logic [31:0] instr_pc;
    lane_idx_t mem_op_cnt;
    logic mem_op_rd;
    logic mem_op_wr;
    logic mem_gpr;
    logic gm_or_lds;
    logic [3:0] sgpr_wr_mask;
    depth_t gpr_op_depth;
    lane_mask_t exec_mask;
    lane_vec_t mem_in_addr;
    logic mem_ack;
    word_t mem_rd_data;
    lane_vec_t vgpr_source1_data;
    vaddr_t decoded_vgpr_source1_addr;
    vaddr_t decoded_dest_addr;
    logic [4*W-1:0] sgpr_dest_data;
    logic [3:0] sgpr_dest_wr_en;
    saddr_t sgpr_dest_addr;
    lane_vec_t vgpr_dest_data;
    logic vgpr_dest_wr_en;
    lane_mask_t vgpr_wr_mask;
    vaddr_t vgpr_dest_addr;
    logic lsu_rdy;
    logic lsu_done;
    wfid_t lsu_done_wfid;
    logic sgpr_instr_done;
    logic vgpr_instr_done;
    logic [31:0] retire_pc;
    logic retire_gm_or_lds;
    logic mem_rd_en;
    logic mem_wr_en;
    word_t mem_out_addr;
    word_t mem_wr_data;
    logic [`LSU_WFID_W:0] mem_tag_req;
    logic mem_gm_or_lds;
    logic vgpr_source1_rd_en;
    vaddr_t vgpr_source1_addr;

    // Operation table
    logic op_write [N_OPS];
    logic op_vector [N_OPS];
    wfid_t op_wfid [N_OPS];
    logic [31:0] op_pc [N_OPS];
    depth_t op_depth [N_OPS];
    lane_idx_t op_cnt [N_OPS];
    lane_mask_t op_mask [N_OPS];
    logic [3:0] op_smask [N_OPS];
    vaddr_t op_dest [N_OPS];
    vaddr_t op_src [N_OPS];
    word_t op_base [N_OPS];  // Lane i sits at base + 64*i
    logic op_gm [N_OPS];

    word_t mem [1024];
    logic [31:0] lfsr = 32'h6c5a_2c71;
    int errors = 0;
    int cur = 0;
    int rows_seen;
    int src_rows;
    int access_cnt;
    int delay = 0;

    tb_clk_gen clk_gen_inst (.clk, .rst);

    lsu_top lsu_top_inst (.*);

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t lfsr_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[W-2:0], lfsr_bit()};
        return r;
    endfunction

    function automatic int widx(input word_t a);
        return int'(a[11:2]);
    endfunction

    function automatic word_t lane_addr(input int idx, input int lane, input int row);
        return op_base[idx] + word_t'(64 * lane) + word_t'(4 * row);
    endfunction

    // Vector row stops at the first inactive lane
    function automatic int active_lanes(input int idx);
        int n;
        n = 0;
        while (n <= int'(op_cnt[idx]) && (!op_vector[idx] || op_mask[idx][n]))
            n++;
        return n;
    endfunction

    // Address of the k-th memory access of an operation
    function automatic word_t access_addr(input int idx, input int k);
        int n;
        n = active_lanes(idx);
        if (op_vector[idx])
            return lane_addr(idx, k % n, k / n);
        return op_base[idx] + word_t'(4 * (k / n + k % n));  // Scalar words follow word 0
    endfunction

    function automatic word_t row_word(input vaddr_t a, input int lane);
        return 32'h5a00_0000 | (word_t'(a) << 8) | word_t'(lane);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("At %0t: %s", $time, what);
        end
    endtask

    task automatic set_op(input int i, input logic wr, input logic vec, input wfid_t id,
                          input logic [31:0] pc, input depth_t dep, input lane_idx_t cnt,
                          input lane_mask_t m, input logic [3:0] sm, input vaddr_t dst,
                          input vaddr_t src, input word_t base, input logic gm);
        op_write[i] = wr;
        op_vector[i] = vec;
        op_wfid[i] = id;
        op_pc[i] = pc;
        op_depth[i] = dep;
        op_cnt[i] = cnt;
        op_mask[i] = m;
        op_smask[i] = sm;
        op_dest[i] = dst;
        op_src[i] = src;
        op_base[i] = base;
        op_gm[i] = gm;
    endtask

    // Memory model with 0 to 3 extra cycles before each acknowledge
    always @(posedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            delay = 0;
        end else if ((mem_rd_en || mem_wr_en) && mem_ack) begin
            check_value("mem_out_addr", mem_out_addr, access_addr(cur, access_cnt));
            check_value("mem_tag_req", 32'(mem_tag_req),
                        32'({op_wfid[cur], ~op_write[cur]}));
            check_value("mem_gm_or_lds", 32'(mem_gm_or_lds), 32'(op_gm[cur]));
            if (mem_wr_en)
                mem[widx(mem_out_addr)] = mem_wr_data;
            access_cnt++;
            mem_ack <= 1'b0;
            delay = int'(lfsr_bits(2));
        end else if (mem_rd_en || mem_wr_en) begin
            if (delay == 0) begin
                mem_ack <= 1'b1;
                mem_rd_data <= mem[widx(mem_out_addr)];
            end else begin
                delay--;
            end
        end
    end

    // Vector register model returns the row one cycle after the request
    always @(posedge clk) begin : reg_model
        lane_vec_t row;
        if (vgpr_source1_rd_en) begin
            for (int i = 0; i < `LSU_LANES; i++)
                row[i*W +: W] = row_word(vgpr_source1_addr, i);
            vgpr_source1_data <= row;
        end
    end

    always @(posedge clk) begin : writeback_monitor
        int n;
        if (!rst && vgpr_dest_wr_en) begin
            n = active_lanes(cur);
            check_value("vgpr_dest_addr", 32'(vgpr_dest_addr), 32'(op_dest[cur]) + rows_seen);
            check_value("vgpr_wr_mask", 32'(vgpr_wr_mask), 32'(op_mask[cur]));
            for (int i = 0; i < n; i++)
                check_value("vgpr_dest_data", vgpr_dest_data[i*W +: W],
                            mem[widx(lane_addr(cur, i, rows_seen))]);
            rows_seen++;
        end
        if (!rst && sgpr_dest_wr_en != 4'b0) begin
            check_value("sgpr_dest_wr_en", 32'(sgpr_dest_wr_en), 32'(op_smask[cur]));
            check_value("sgpr_dest_addr", 32'(sgpr_dest_addr),
                        32'(op_dest[cur][`LSU_SADDR_W-1:0]) + rows_seen);
            for (int k = 0; k <= int'(op_cnt[cur]) && k < 4; k++)
                check_value("sgpr_dest_data", sgpr_dest_data[k*W +: W],
                            mem[widx(op_base[cur] + word_t'(4 * (rows_seen + k)))]);
            rows_seen++;
        end
        if (!rst && vgpr_source1_rd_en) begin
            check_value("vgpr_source1_addr", 32'(vgpr_source1_addr),
                        32'(op_src[cur]) + src_rows);
            src_rows++;
        end
    end

    task automatic run_op(input int idx);
        lane_vec_t addrs;
        int n;
        int rows;
        cur = idx;
        while (!lsu_rdy)
            @(posedge clk);
        rows_seen = 0;
        src_rows = 0;
        access_cnt = 0;
        for (int i = 0; i < `LSU_LANES; i++)
            addrs[i*W +: W] = lane_addr(idx, i, 0);
        mem_op_rd <= !op_write[idx];
        mem_op_wr <= op_write[idx];
        mem_gpr <= op_vector[idx];
        lsu_wfid <= op_wfid[idx];
        instr_pc <= op_pc[idx];
        gpr_op_depth <= op_depth[idx];
        mem_op_cnt <= op_cnt[idx];
        exec_mask <= op_mask[idx];
        sgpr_wr_mask <= op_smask[idx];
        decoded_dest_addr <= op_dest[idx];
        decoded_vgpr_source1_addr <= op_src[idx];
        mem_in_addr <= addrs;
        gm_or_lds <= op_gm[idx];
        @(posedge clk);
        mem_op_rd <= 1'b0;
        mem_op_wr <= 1'b0;
        @(posedge clk);
        while (!lsu_done)
            @(posedge clk);
        check_value("lsu_done_wfid", 32'(lsu_done_wfid), 32'(op_wfid[idx]));
        check_value("retire_pc", retire_pc, op_pc[idx]);
        check_value("retire_gm_or_lds", 32'(retire_gm_or_lds), 32'(op_gm[idx]));
        check_value("sgpr_instr_done", 32'(sgpr_instr_done),
                    32'(!op_write[idx] && !op_vector[idx]));
        check_value("vgpr_instr_done", 32'(vgpr_instr_done),
                    32'(!op_write[idx] && op_vector[idx]));
        @(posedge clk);
        check_true(lsu_rdy && !lsu_done, "lsu_rdy did not rise after a single lsu_done cycle");
        n = active_lanes(idx);
        rows = int'(op_depth[idx]) + 1;
        check_value("memory access count", access_cnt, rows * n);
        check_value("register row writes", rows_seen, op_write[idx] ? 0 : rows);
        check_value("source row reads", src_rows, op_write[idx] ? rows : 0);
        if (op_write[idx]) begin
            for (int r = 0; r < rows; r++)
                for (int i = 0; i < n; i++)
                    check_value("stored word", mem[widx(lane_addr(idx, i, r))],
                                row_word(op_src[idx] + vaddr_t'(r), i));
        end
    endtask

    initial begin
        #(N_OPS * 200 * 8);
        $display("Timeout: an operation never finished");
        $display("test failed");
        $finish;
    end

    initial begin
        mem_op_rd = 1'b0;
        mem_op_wr = 1'b0;
        mem_gpr = 1'b0;
        lsu_wfid = '0;
        instr_pc = '0;
        mem_op_cnt = '0;
        gm_or_lds = 1'b0;
        sgpr_wr_mask = '0;
        gpr_op_depth = '0;
        exec_mask = '0;
        mem_in_addr = '0;
        mem_ack = 1'b0;
        mem_rd_data = '0;
        vgpr_source1_data = '0;
        decoded_vgpr_source1_addr = '0;
        decoded_dest_addr = '0;
        for (int a = 0; a < 1024; a++)
            mem[a] = lfsr_bits(32);
        //     wr    vec   wfid   pc            dep   cnt   mask      smask    dst      src
        set_op(0, 1'b0, 1'b1, 6'd5, 32'h0000_1000, 2'd3, 3'd7, 8'hff, 4'h0, 10'h020, 10'h000,
               32'h100, 1'b1);
        set_op(1, 1'b0, 1'b1, 6'd9, 32'h0000_2040, 2'd1, 3'd7, 8'hf7, 4'h0, 10'h040, 10'h000,
               32'h800, 1'b0);
        set_op(2, 1'b0, 1'b0, 6'd17, 32'h0000_3300, 2'd1, 3'd3, 8'h00, 4'hb, 10'h1f0, 10'h000,
               32'h300, 1'b1);
        set_op(3, 1'b1, 1'b1, 6'd33, 32'h0000_4abc, 2'd2, 3'd7, 8'hff, 4'h0, 10'h000, 10'h080,
               32'hc00, 1'b1);
        set_op(4, 1'b1, 1'b1, 6'd62, 32'h0000_5008, 2'd1, 3'd7, 8'h1f, 4'h0, 10'h000, 10'h1c3,
               32'he00, 1'b0);
        @(posedge clk);
        while (rst)
            @(posedge clk);
        check_true(lsu_rdy && !lsu_done && !sgpr_instr_done && !vgpr_instr_done,
                   "ready or done outputs wrong after reset");
        check_true(!mem_rd_en && !mem_wr_en && sgpr_dest_wr_en == 4'b0 && !vgpr_dest_wr_en,
                   "memory or register write strobes active after reset");
        check_true(!vgpr_source1_rd_en, "register read request active after reset");
        for (int i = 0; i < N_OPS; i++)
            run_op(i);
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/lsu_mem_seq.sv
src/lsu_lane_buffer.sv
src/lsu_writeback.sv
src/lsu_top.sv
bench/tb_clk_gen.sv
bench/tb_lsu.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing
TOP = tb_lsu
FILELIST = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
